//--- Makefile
TOP := tb_rv32_mem_pipe

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module rv32_mem_pipe hdl/rv32_mem_pkg.sv \
		hdl/mem_addr_gen.sv hdl/mem_stage.sv hdl/wb_stage.sv hdl/rv32_mem_pipe.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- hdl/mem_addr_gen.sv
`default_nettype none

module mem_addr_gen (
    input  rv32_mem_pkg::mem_kind_e                  kind_i,
    input  logic [2:0]                               funct3_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]            addr_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]            store_data_i,
    output logic [rv32_mem_pkg::XLEN-1:0]            word_addr_o,
    output logic [rv32_mem_pkg::BYTES_PER_WORD-1:0]  sel_o,
    output logic [rv32_mem_pkg::XLEN-1:0]            lane_data_o,
    output logic                                     trap_o
);

    logic [1:0]                              offset;
    logic [rv32_mem_pkg::BYTES_PER_WORD-1:0] base_mask;
    logic                                    bad_f3;
    logic                                    misaligned;

    always_comb begin
        offset      = addr_i[1:0];
        word_addr_o = {addr_i[rv32_mem_pkg::XLEN-1:2], 2'b00}; // word aligned
        lane_data_o = store_data_i << {offset, 3'b000};       // byte lanes
        base_mask   = '0;
        bad_f3      = 1'b0;
        misaligned  = 1'b0;

        if (kind_i == rv32_mem_pkg::mem_load) begin
            case (funct3_i)
                rv32_mem_pkg::f3_lb, rv32_mem_pkg::f3_lbu: begin
                    base_mask = 4'b0001;
                end
                rv32_mem_pkg::f3_lh, rv32_mem_pkg::f3_lhu: begin
                    base_mask  = 4'b0011;
                    misaligned = offset[0];
                end
                rv32_mem_pkg::f3_lw: begin
                    base_mask  = 4'b1111;
                    misaligned = |offset;
                end
                default: bad_f3 = 1'b1;
            endcase
        end else if (kind_i == rv32_mem_pkg::mem_store) begin
            case (funct3_i)
                rv32_mem_pkg::f3_sb: base_mask = 4'b0001;
                rv32_mem_pkg::f3_sh: begin
                    base_mask  = 4'b0011;
                    misaligned = offset[0]; // upper byte would fall off the word
                end
                rv32_mem_pkg::f3_sw: begin
                    base_mask  = 4'b1111;
                    misaligned = |offset;
                end
                default: bad_f3 = 1'b1;
            endcase
        end

        sel_o  = base_mask << offset; // zero for mem_none
        trap_o = bad_f3 | misaligned;
    end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     valid_i,
    input  rv32_mem_pkg::mem_kind_e                  kind_i,
    input  logic [2:0]                               funct3_i,
    input  logic [rv32_mem_pkg::REG_ADDR_W-1:0]      rd_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]            alu_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]            rs2_i,
    input  logic                                     wb_ack_i,
    output logic                                     ready_o,
    output logic                                     advance_o,
    output rv32_mem_pkg::mem_kind_e                  kind_o,
    output logic [2:0]                               funct3_o,
    output logic [1:0]                               offset_o,
    output logic [rv32_mem_pkg::REG_ADDR_W-1:0]      rd_o,
    output logic [rv32_mem_pkg::XLEN-1:0]            alu_o,
    output logic                                     trap_o,
    output logic [rv32_mem_pkg::ORDER_W-1:0]         order_o,
    output logic                                     wb_cyc_o,
    output logic                                     wb_stb_o,
    output logic                                     wb_we_o,
    output logic [rv32_mem_pkg::XLEN-1:0]            wb_adr_o,
    output logic [rv32_mem_pkg::BYTES_PER_WORD-1:0]  wb_sel_o,
    output logic [rv32_mem_pkg::XLEN-1:0]            wb_dat_o
);

    logic [rv32_mem_pkg::XLEN-1:0]           gen_addr;
    logic [rv32_mem_pkg::BYTES_PER_WORD-1:0] gen_sel;
    logic [rv32_mem_pkg::XLEN-1:0]           gen_data;
    logic                                    gen_trap;

    logic                                    full_q;
    rv32_mem_pkg::mem_kind_e                 kind_q;
    logic                                    trap_q;
    logic [rv32_mem_pkg::ORDER_W-1:0]        order_cnt_q;
    logic [rv32_mem_pkg::XLEN-1:0]           adr_q;
    logic [2:0]                              funct3_q;
    logic [rv32_mem_pkg::REG_ADDR_W-1:0]     rd_q;
    logic [rv32_mem_pkg::XLEN-1:0]           alu_q;
    logic [rv32_mem_pkg::BYTES_PER_WORD-1:0] sel_q;
    logic [rv32_mem_pkg::XLEN-1:0]           dat_q;
    logic [rv32_mem_pkg::ORDER_W-1:0]        order_q;

    logic accept;
    logic bus_access;

    mem_addr_gen u_addr_gen (
        .kind_i       (kind_i),
        .funct3_i     (funct3_i),
        .addr_i       (alu_i),
        .store_data_i (rs2_i),
        .word_addr_o  (gen_addr),
        .sel_o        (gen_sel),
        .lane_data_o  (gen_data),
        .trap_o       (gen_trap)
    );

    assign bus_access = full_q && (kind_q != rv32_mem_pkg::mem_none) && !trap_q;
    assign advance_o  = full_q && (!bus_access || wb_ack_i); // only place this is decided
    assign ready_o    = !full_q || advance_o;
    assign accept     = valid_i && ready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full_q      <= 1'b0;
            kind_q      <= rv32_mem_pkg::mem_none;
            trap_q      <= 1'b0;
            order_cnt_q <= '0;
            adr_q       <= rv32_mem_pkg::RESET_ADDR;
        end else if (accept) begin
            full_q      <= 1'b1;
            kind_q      <= kind_i;
            trap_q      <= gen_trap;
            order_cnt_q <= order_cnt_q + 1'b1; // one number per accepted instruction
            adr_q       <= gen_addr;
        end else if (advance_o) begin
            full_q <= 1'b0; // stage drained, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            funct3_q <= funct3_i;
            rd_q     <= rd_i;
            alu_q    <= alu_i;
            sel_q    <= gen_sel;
            dat_q    <= gen_data;
            order_q  <= order_cnt_q;
        end
    end

    // classic cycle, held until ack
    assign wb_cyc_o = bus_access;
    assign wb_stb_o = bus_access;
    assign wb_we_o  = bus_access && (kind_q == rv32_mem_pkg::mem_store);
    assign wb_adr_o = adr_q;
    assign wb_sel_o = bus_access ? sel_q : '0;
    assign wb_dat_o = dat_q;

    assign kind_o   = kind_q;
    assign funct3_o = funct3_q;
    assign offset_o = alu_q[1:0]; // byte offset for load extraction
    assign rd_o     = rd_q;
    assign alu_o    = alu_q;
    assign trap_o   = trap_q;
    assign order_o  = order_q;

endmodule

`default_nettype wire

//--- hdl/rv32_mem_pipe.sv
`default_nettype none

module rv32_mem_pipe (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     valid_i,
    output logic                                     ready_o,
    input  rv32_mem_pkg::mem_kind_e                  kind_i,
    input  logic [2:0]                               funct3_i,
    input  logic [rv32_mem_pkg::REG_ADDR_W-1:0]      rd_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]            alu_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]            rs2_i,
    output logic                                     wb_cyc_o,
    output logic                                     wb_stb_o,
    output logic                                     wb_bus_we_o, // wishbone WE_O
    output logic [rv32_mem_pkg::XLEN-1:0]            wb_adr_o,
    output logic [rv32_mem_pkg::BYTES_PER_WORD-1:0]  wb_sel_o,
    output logic [rv32_mem_pkg::XLEN-1:0]            wb_dat_o,
    input  logic [rv32_mem_pkg::XLEN-1:0]            wb_dat_i,
    input  logic                                     wb_ack_i,
    output logic                                     wb_valid_o,
    output logic                                     wb_we_o,     // register file write
    output logic [rv32_mem_pkg::REG_ADDR_W-1:0]      wb_rd_o,
    output logic [rv32_mem_pkg::XLEN-1:0]            wb_data_o,
    output logic [rv32_mem_pkg::ORDER_W-1:0]         wb_order_o,
    output logic                                     wb_trap_o
);

    logic                                advance;
    rv32_mem_pkg::mem_kind_e             mem_kind;
    logic [2:0]                          mem_funct3;
    logic [1:0]                          mem_offset;
    logic [rv32_mem_pkg::REG_ADDR_W-1:0] mem_rd;
    logic [rv32_mem_pkg::XLEN-1:0]       mem_alu;
    logic                                mem_trap;
    logic [rv32_mem_pkg::ORDER_W-1:0]    mem_order;

    mem_stage u_mem_stage (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (valid_i),
        .kind_i    (kind_i),
        .funct3_i  (funct3_i),
        .rd_i      (rd_i),
        .alu_i     (alu_i),
        .rs2_i     (rs2_i),
        .wb_ack_i  (wb_ack_i),
        .ready_o   (ready_o),
        .advance_o (advance),
        .kind_o    (mem_kind),
        .funct3_o  (mem_funct3),
        .offset_o  (mem_offset),
        .rd_o      (mem_rd),
        .alu_o     (mem_alu),
        .trap_o    (mem_trap),
        .order_o   (mem_order),
        .wb_cyc_o  (wb_cyc_o),
        .wb_stb_o  (wb_stb_o),
        .wb_we_o   (wb_bus_we_o),
        .wb_adr_o  (wb_adr_o),
        .wb_sel_o  (wb_sel_o),
        .wb_dat_o  (wb_dat_o)
    );

    wb_stage u_wb_stage (
        .clk        (clk),
        .rst        (rst),
        .advance_i  (advance),
        .kind_i     (mem_kind),
        .funct3_i   (mem_funct3),
        .offset_i   (mem_offset),
        .rd_i       (mem_rd),
        .alu_i      (mem_alu),
        .trap_i     (mem_trap),
        .order_i    (mem_order),
        .wb_dat_i   (wb_dat_i),    // sampled on the ack edge
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .wb_order_o (wb_order_o),
        .wb_trap_o  (wb_trap_o)
    );

endmodule

`default_nettype wire

//--- hdl/rv32_mem_pkg.sv
`default_nettype none

package rv32_mem_pkg;

    localparam int XLEN           = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int REG_ADDR_W     = 5;
    localparam int ORDER_W        = 64;

    localparam logic [XLEN-1:0] RESET_ADDR = 32'h4000_0000; // bus address while idle out of reset

    // memory access kind carried with each instruction
    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_kind_e;

    // RV32I load funct3 codes
    typedef enum logic [2:0] {
        f3_lb  = 3'd0,
        f3_lh  = 3'd1,
        f3_lw  = 3'd2,
        f3_lbu = 3'd4,
        f3_lhu = 3'd5
    } load_f3_e;

    // RV32I store funct3 codes
    typedef enum logic [2:0] {
        f3_sb = 3'd0,
        f3_sh = 3'd1,
        f3_sw = 3'd2
    } store_f3_e;

endpackage

`default_nettype wire

//--- hdl/wb_stage.sv
`default_nettype none

module wb_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 advance_i,
    input  rv32_mem_pkg::mem_kind_e              kind_i,
    input  logic [2:0]                           funct3_i,
    input  logic [1:0]                           offset_i,
    input  logic [rv32_mem_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]        alu_i,
    input  logic                                 trap_i,
    input  logic [rv32_mem_pkg::ORDER_W-1:0]     order_i,
    input  logic [rv32_mem_pkg::XLEN-1:0]        wb_dat_i,
    output logic                                 wb_valid_o,
    output logic                                 wb_we_o,
    output logic [rv32_mem_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic [rv32_mem_pkg::XLEN-1:0]        wb_data_o,
    output logic [rv32_mem_pkg::ORDER_W-1:0]     wb_order_o,
    output logic                                 wb_trap_o
);

    localparam int XL = rv32_mem_pkg::XLEN;

    logic [XL-1:0] shifted;
    logic [XL-1:0] load_val;
    logic [XL-1:0] result;
    logic          reg_we;

    always_comb begin
        shifted = wb_dat_i >> {offset_i, 3'b000}; // addressed lane down to bit 0
        case (funct3_i)
            rv32_mem_pkg::f3_lb:  load_val = {{(XL-8){shifted[7]}}, shifted[7:0]};
            rv32_mem_pkg::f3_lbu: load_val = {{(XL-8){1'b0}}, shifted[7:0]};
            rv32_mem_pkg::f3_lh:  load_val = {{(XL-16){shifted[15]}}, shifted[15:0]};
            rv32_mem_pkg::f3_lhu: load_val = {{(XL-16){1'b0}}, shifted[15:0]};
            rv32_mem_pkg::f3_lw:  load_val = wb_dat_i;
            default:              load_val = '0; // trapped, never written
        endcase

        if (kind_i == rv32_mem_pkg::mem_load) begin
            result = load_val;
        end else begin
            result = alu_i; // alu value, or store address
        end

        reg_we = !trap_i && (kind_i != rv32_mem_pkg::mem_store);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            wb_trap_o  <= 1'b0;
        end else begin
            wb_valid_o <= advance_i; // one cycle pulse per instruction
            if (advance_i) begin
                wb_we_o   <= reg_we;
                wb_trap_o <= trap_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            wb_rd_o    <= rd_i;
            wb_data_o  <= result;
            wb_order_o <= order_i;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/rv32_mem_pkg.sv
hdl/mem_addr_gen.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/rv32_mem_pipe.sv
testbench/wb_mem_model.sv
testbench/tb_rv32_mem_pipe.sv

//--- testbench/tb_rv32_mem_pipe.sv
`default_nettype none

module tb_rv32_mem_pipe;

    localparam logic [31:0] BASE = 32'h0000_1000;

    logic                    clk;
    logic                    rst;
    logic                    valid;
    logic                    ready;
    rv32_mem_pkg::mem_kind_e kind;
    logic [2:0]              funct3;
    logic [4:0]              rd;
    logic [31:0]             alu;
    logic [31:0]             rs2;
    logic                    cyc;
    logic                    stb;
    logic                    bus_we;
    logic                    ack;
    logic [31:0]             adr;
    logic [3:0]              sel;
    logic [31:0]             dat_w;
    logic [31:0]             dat_r;
    logic                    wb_valid;
    logic                    wb_we;
    logic                    wb_trap;
    logic [4:0]              wb_rd;
    logic [31:0]             wb_data;
    logic [63:0]             wb_order;

    logic [38:0] wb_q[$];   // trap, we, rd, data
    logic [68:0] bus_q[$];  // we, sel, adr, dat
    logic [31:0] shadow [0:15];
    logic [63:0] wb_count;
    logic [31:0] adr_prev;
    logic [3:0]  sel_prev;
    logic        wait_prev;
    integer      seed;
    int          errors;
    int          checks;
    int          issued;

    rv32_mem_pipe dut (
        .clk(clk), .rst(rst), .valid_i(valid), .ready_o(ready), .kind_i(kind),
        .funct3_i(funct3), .rd_i(rd), .alu_i(alu), .rs2_i(rs2),
        .wb_cyc_o(cyc), .wb_stb_o(stb), .wb_bus_we_o(bus_we), .wb_adr_o(adr),
        .wb_sel_o(sel), .wb_dat_o(dat_w), .wb_dat_i(dat_r), .wb_ack_i(ack),
        .wb_valid_o(wb_valid), .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .wb_order_o(wb_order), .wb_trap_o(wb_trap)
    );

    wb_mem_model u_mem (
        .clk(clk), .rst(rst), .cyc_i(cyc), .stb_i(stb), .we_i(bus_we), .adr_i(adr),
        .sel_i(sel), .dat_i(dat_w), .dat_o(dat_r), .ack_o(ack)
    );

    always #2 clk = ~clk;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] addr_of(input logic [3:0] w, input logic [1:0] off);
        return BASE | {26'd0, w, off};
    endfunction

    // reference model for every accepted instruction
    task automatic predict(input logic [1:0] k, input logic [2:0] f3, input logic [4:0] r,
                           input logic [31:0] a, input logic [31:0] d);
        logic [1:0]  off;
        logic [3:0]  mask;
        logic        trap;
        logic [31:0] lane;
        logic [31:0] val;
        off  = a[1:0];
        mask = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
        trap = (f3[1:0] == 2'd1 && off[0]) || (f3[1:0] == 2'd2 && off != 2'd0);
        if (k == rv32_mem_pkg::mem_load) begin
            trap = trap || f3[1:0] == 2'd3 || f3 >= 3'd6;
        end else if (k == rv32_mem_pkg::mem_store) begin
            trap = trap || f3 > 3'd2;
        end else begin
            trap = 1'b0;
        end
        val = a;
        if (k != rv32_mem_pkg::mem_none && !trap) begin
            lane = d << (8 * off);
            bus_q.push_back({k == rv32_mem_pkg::mem_store, mask << off, a[31:2], 2'b00, lane});
            for (int b = 0; b < 4; b++) begin
                if (k == rv32_mem_pkg::mem_store && (mask << off) >> b & 4'd1) begin
                    shadow[a[5:2]][8*b +: 8] = lane[8*b +: 8];
                end
            end
            lane = shadow[a[5:2]] >> (8 * off);
            case (f3)
                3'd0:    val = {{24{lane[7]}}, lane[7:0]};
                3'd1:    val = {{16{lane[15]}}, lane[15:0]};
                3'd4:    val = {24'd0, lane[7:0]};
                3'd5:    val = {16'd0, lane[15:0]};
                default: val = lane;
            endcase
            if (k == rv32_mem_pkg::mem_store) val = a;
        end
        wb_q.push_back({trap, !trap && k != rv32_mem_pkg::mem_store, r, val});
    endtask

    always @(negedge clk) begin
        logic [38:0] exp_wb;
        logic [68:0] exp_bus;
        if (rst) begin
            for (int i = 0; i < 16; i++) shadow[i] = u_mem.mem[i];
            wait_prev = 1'b0;
        end else begin
            if (wb_valid) begin
                assert (wb_q.size() > 0) else begin
                    $display("writeback seen with no instruction in flight");
                    errors++;
                end
                if (wb_q.size() > 0) begin
                    exp_wb = wb_q.pop_front();
                    compare("wb_trap_o", 64'(wb_trap), 64'(exp_wb[38]));
                    compare("wb_we_o", 64'(wb_we), 64'(exp_wb[37]));
                    compare("wb_order_o", wb_order, wb_count);
                    if (exp_wb[37]) begin
                        compare("wb_rd_o", 64'(wb_rd), 64'(exp_wb[36:32]));
                        compare("wb_data_o", 64'(wb_data), 64'(exp_wb[31:0]));
                    end
                end
                wb_count++;
            end
            if (cyc) begin
                assert (bus_q.size() > 0) else begin
                    $display("bus cycle started with no load or store pending");
                    errors++;
                end
                if (bus_q.size() > 0) begin
                    exp_bus = bus_q[0];
                    compare("wb_bus_we_o", 64'(bus_we), 64'(exp_bus[68]));
                    compare("wb_sel_o", 64'(sel), 64'(exp_bus[67:64]));
                    compare("wb_adr_o", 64'(adr), 64'(exp_bus[63:32]));
                    if (exp_bus[68]) compare("wb_dat_o", 64'(dat_w), 64'(exp_bus[31:0]));
                    if (ack) void'(bus_q.pop_front());
                end
                if (!ack) compare("ready_o", 64'(ready), 64'd0); // stalled on the bus
            end
            if (wait_prev) begin
                assert (stb && adr == adr_prev && sel == sel_prev) else begin
                    $display("wb_stb_o dropped or address or select changed before ack");
                    errors++;
                end
            end
            wait_prev = stb && !ack;
            adr_prev  = adr;
            sel_prev  = sel;
            if (valid && ready) predict(kind, funct3, rd, alu, rs2);
        end
    end

    // holds the inputs until the accept edge
    task automatic issue(input logic [1:0] k, input logic [2:0] f3, input logic [31:0] a,
                         input logic [31:0] d);
        int t;
        t      = 0;
        valid  = 1'b1;
        kind   = rv32_mem_pkg::mem_kind_e'(k);
        funct3 = f3;
        rd     = 5'(issued);
        alu    = a;
        rs2    = d;
        @(negedge clk);
        while (!ready && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (!ready) begin
            $display("instruction %0d was never accepted", issued);
            errors++;
        end
        @(posedge clk);
        #1;
        valid  = 1'b0;
        issued++;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (wb_q.size() != 0 && t < 300) begin
            @(negedge clk);
            t++;
        end
        if (wb_q.size() != 0) begin
            $display("%0d instructions never reached writeback", wb_q.size());
            errors++;
        end
        if (bus_q.size() != 0) begin
            $display("%0d expected bus cycles never happened", bus_q.size());
            errors++;
            bus_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report(input string name, input int start);
        $display("test %-14s %0d errors", name, errors - start);
    endtask

    initial begin
        logic [31:0] r;
        logic [1:0]  k;
        int          start;
        clk = 1'b0;
        rst = 1'b1;
        valid = 1'b0;
        kind = rv32_mem_pkg::mem_none;
        funct3 = 3'd0;
        rd = 5'd0;
        alu = 32'd0;
        rs2 = 32'd0;
        seed = 32'hfbfd_0f69;
        errors = 0;
        checks = 0;
        issued = 0;
        wb_count = 64'd0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        start = errors;
        @(negedge clk);
        compare("wb_valid_o", 64'(wb_valid), 64'd0);
        compare("wb_cyc_o", 64'(cyc), 64'd0);
        compare("wb_stb_o", 64'(stb), 64'd0);
        compare("ready_o", 64'(ready), 64'd1);
        @(posedge clk);
        #1;
        report("reset", start);

        start = errors;
        for (int i = 0; i < 8; i++) issue(rv32_mem_pkg::mem_none, 3'd0, $random(seed), 32'd0);
        drain();
        report("alu", start);

        start = errors;
        for (int off = 0; off < 4; off++) begin
            issue(rv32_mem_pkg::mem_store, rv32_mem_pkg::f3_sb, addr_of(4'd3, 2'(off)),
                  $random(seed));
            if (off % 2 == 0) begin
                issue(rv32_mem_pkg::mem_store, rv32_mem_pkg::f3_sh, addr_of(4'd5, 2'(off)),
                      $random(seed));
            end
        end
        issue(rv32_mem_pkg::mem_store, rv32_mem_pkg::f3_sw, addr_of(4'd7, 2'd0), $random(seed));
        drain();
        for (int i = 0; i < 16; i++) begin
            compare($sformatf("mem[%0d]", i), 64'(u_mem.mem[i]), 64'(shadow[i]));
        end
        report("stores", start);

        start = errors;
        for (int j = 0; j < 4; j++) begin
            for (int off = 0; off < 4; off++) begin
                r = addr_of(4'(3 + 2 * j), 2'(off));
                issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lb, r, 32'd0);
                issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lbu, r, 32'd0);
                if (off % 2 == 0) begin
                    issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lh, r, 32'd0);
                    issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lhu, r, 32'd0);
                end
                if (off == 0) issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lw, r, 32'd0);
            end
        end
        drain();
        report("loads", start);

        start = errors;
        for (int f = 3; f < 8; f++) begin
            issue(rv32_mem_pkg::mem_store, 3'(f), addr_of(4'd2, 2'd0), 32'h1234_5678);
            if (f != 4 && f != 5) issue(rv32_mem_pkg::mem_load, 3'(f), addr_of(4'd2, 2'd0), 32'd0);
        end
        for (int off = 1; off < 4; off++) begin
            issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lw, addr_of(4'd2, 2'(off)), 32'd0);
            issue(rv32_mem_pkg::mem_store, rv32_mem_pkg::f3_sw, addr_of(4'd2, 2'(off)), 32'd1);
            if (off % 2 == 1) begin
                issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lh, addr_of(4'd2, 2'(off)), 32'd0);
                issue(rv32_mem_pkg::mem_load, rv32_mem_pkg::f3_lhu, addr_of(4'd2, 2'(off)), 32'd0);
                issue(rv32_mem_pkg::mem_store, rv32_mem_pkg::f3_sh, addr_of(4'd2, 2'(off)), 32'd1);
            end
        end
        drain();
        report("traps", start);

        start = errors;
        for (int i = 0; i < 80; i++) begin
            r = $random(seed);
            k = (r[1:0] == 2'd3) ? 2'd1 : r[1:0]; // loads twice as often
            issue(k, r[4:2], addr_of(r[11:8], r[13:12]), $random(seed));
        end
        drain();
        report("backpressure", start);

        $display("tests 6, issued %0d, checks %0d, errors %0d", issued, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/wb_mem_model.sv
`default_nettype none

module wb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0] mem [0:15];
    integer      seed;
    logic [31:0] draw;
    logic [1:0]  wait_cnt;
    logic        busy;

    initial begin
        seed = 32'hfbfd_0f69;
        for (int i = 0; i < 16; i++) begin
            mem[i] = (i + 1) * 32'h9e37_79b9; // every word differs, high bits set
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o    <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            dat_o    <= 32'd0;
        end else begin
            ack_o <= 1'b0; // single cycle ack
            if (cyc_i && stb_i && !ack_o) begin
                draw = $random(seed);
                if (busy ? (wait_cnt == 2'd0) : (draw[1:0] == 2'd0)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (we_i && sel_i[b]) begin
                            mem[adr_i[5:2]][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end
                    dat_o <= mem[adr_i[5:2]];
                    ack_o <= 1'b1;
                    busy  <= 1'b0;
                end else if (busy) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    busy     <= 1'b1;
                    wait_cnt <= draw[1:0] - 2'd1; // 1 to 3 more wait cycles
                end
            end
        end
    end

endmodule

`default_nettype wire
